//--- text_video.f
+incdir+.
video_regs_pkg.sv
video_render_pkg.sv
apb_reg_file.sv
vram.sv
char_line_fetch.sv
line_buffer_palette.sv
text_video_top.sv
tb_text_video.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_text_video
FILELIST  = text_video.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_text_video.sv
`timescale 1ns/1ps
`default_nettype none

`include "text_video_macros.svh"

module tb_text_video;
   import video_regs_pkg::*;
   import video_render_pkg::*;

   localparam int LINE_TIMEOUT = 1000;   // 80 columns need 481 cycles

   logic                   sys_clk;
   logic                   arst_n;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   logic [`APB_ADDR_W-1:0] paddr;
   logic [7:0]             pwdata;
   logic [7:0]             prdata;
   logic                   pready;
   logic [`PIX_ADDR_W-1:0] pix_addr;
   color565_t              pix_rgb;
   logic                   line_done;

   // reference model of what the cpu has programmed
   logic [7:0] vmem [`VRAM_DEPTH];
   color565_t  pal_model [`PAL_DEPTH];
   pal_index_t pal_ptr;
   vram_addr_t text_ref;
   vram_addr_t attr_ref;
   logic [7:0] charset_ref;
   logic [2:0] scan_ref;

   integer seed = 32'h5dde_5fc0;
   int     errors;
   int     checks;
   int     tests;
   int     err_mark;

   text_video_top DUT (
      .sys_clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
      .prdata, .pready, .pix_addr, .pix_rgb, .line_done
   );

   initial begin
      sys_clk = 1'b0;
      forever #2 sys_clk = ~sys_clk;
   end

   task automatic check_rgb(input string name, input color565_t exp, input color565_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Mismatch %s: expected %h, got %h", name, exp, act);
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Mismatch %s: expected %h, got %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Mismatch %s: expected %h, got %h", name, exp, act);
      end
   endtask

   // setup cycle, access cycle, register updates on the access edge
   task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr, input logic [7:0] data);
      @(posedge sys_clk);
      psel   <= 1'b1;
      pwrite <= 1'b1;
      paddr  <= addr;
      pwdata <= data;
      @(posedge sys_clk);
      penable <= 1'b1;
      @(posedge sys_clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr, output logic [7:0] data);
      @(posedge sys_clk);
      psel   <= 1'b1;
      pwrite <= 1'b0;
      paddr  <= addr;
      @(posedge sys_clk);
      penable <= 1'b1;
      @(negedge sys_clk);
      data = prdata;   // mid access phase
      check_bit("pready", 1'b1, pready);
      @(posedge sys_clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic set_vaddr(input vram_addr_t a);
      apb_write(REG_VADDR_LO, a[7:0]);
      apb_write(REG_VADDR_MID, a[15:8]);
      apb_write(REG_VADDR_HI, {7'd0, a[16]});
   endtask

   task automatic vram_put(input vram_addr_t a, input logic [7:0] d);
      set_vaddr(a);
      apb_write(REG_VDATA, d);
      vmem[a] = d;
   endtask

   // fills n bytes from a through the auto-incrementing data port
   task automatic vram_fill_random(input vram_addr_t a, input int n);
      logic [7:0] d;
      set_vaddr(a);
      for (int i = 0; i < n; i++) begin
         d = 8'($random(seed));
         apb_write(REG_VDATA, d);
         vmem[a + vram_addr_t'(i)] = d;
      end
   endtask

   task automatic set_bases(input vram_addr_t t, input vram_addr_t a, input logic [7:0] cs);
      apb_write(REG_TEXT_LO, t[7:0]);
      apb_write(REG_TEXT_MID, t[15:8]);
      apb_write(REG_TEXT_HI, {7'd0, t[16]});
      apb_write(REG_ATTR_LO, a[7:0]);
      apb_write(REG_ATTR_MID, a[15:8]);
      apb_write(REG_ATTR_HI, {7'd0, a[16]});
      apb_write(REG_CHARSET, cs);
      text_ref    = t;
      attr_ref    = a;
      charset_ref = cs;
   endtask

   task automatic set_pal_index(input pal_index_t i);
      apb_write(REG_PAL_INDEX, i);
      pal_ptr = i;
   endtask

   task automatic pal_push(input color565_t c);
      apb_write(REG_PAL_DATA, c[7:0]);
      apb_write(REG_PAL_DATA, c[15:8]);
      pal_model[pal_ptr] = c;
      pal_ptr = pal_ptr + 8'd1;
   endtask

   // page = charset[6:0] + char[7], then char[6:0], then scanline
   function automatic vram_addr_t font_addr_of(input logic [7:0] ch, input logic [2:0] scan);
      logic [6:0] page;
      page = charset_ref[6:0] + {6'd0, ch[7]};
      return {page, ch[6:0], scan};
   endfunction

   function automatic color565_t expected_pixel(input int p);
      int         col;
      int         k;
      logic [7:0] ch;
      logic [7:0] at;
      logic [7:0] font;
      logic [3:0] idx;
      col  = p / 8;
      k    = p % 8;
      ch   = vmem[text_ref + vram_addr_t'(col)];
      at   = vmem[attr_ref + vram_addr_t'(col)];
      font = vmem[font_addr_of(ch, scan_ref)];
      idx  = font[7-k] ? at[3:0] : at[7:4];   // leftmost pixel is bit 7
      return pal_model[{4'h0, idx}];
   endfunction

   task automatic check_pixel(input int p);
      @(posedge sys_clk);
      pix_addr <= p[`PIX_ADDR_W-1:0];
      repeat (2) @(posedge sys_clk);
      @(negedge sys_clk);
      check_rgb($sformatf("pix_rgb[%0d]", p), expected_pixel(p), pix_rgb);
   endtask

   task automatic wait_line_done(output logic seen);
      int n;
      seen = 1'b0;
      n    = 0;
      while (!seen && n < LINE_TIMEOUT) begin
         @(negedge sys_clk);
         if (line_done === 1'b1) seen = 1'b1;
         n++;
      end
      if (!seen) begin
         errors++;
         $display("timeout: line_done did not arrive within %0d cycles", LINE_TIMEOUT);
      end
   endtask

   task automatic render(input int cols, input logic [2:0] scan, output logic ok);
      apb_write(REG_COLS, 8'(cols));
      apb_write(REG_START, {5'd0, scan});
      scan_ref = scan;
      wait_line_done(ok);
   endtask

   task automatic report_test(input string name);
      tests++;
      if (errors == err_mark) $display("test %0d %s: ok", tests, name);
      else $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
      err_mark = errors;
   endtask

   task automatic test_reset_state();
      logic [7:0] rd;
      logic       seen;
      apb_read(REG_STATUS, rd);
      check_byte("prdata status", 8'h00, rd);
      check_bit("busy", 1'b0, rd[0]);
      seen = 1'b0;
      repeat (20) begin
         @(negedge sys_clk);
         if (line_done !== 1'b0) seen = 1'b1;
      end
      check_bit("line_done", 1'b0, seen);
      apb_read(8'h0e, rd);
      check_byte("prdata 0x0e", 8'h00, rd);
      apb_read(8'h12, rd);
      check_byte("prdata 0x12", 8'h00, rd);
      apb_read(8'hff, rd);
      check_byte("prdata 0xff", 8'h00, rd);
   endtask

   task automatic test_palette_load();
      pal_index_t base;
      logic [7:0] rd;
      logic       ok;
      base = 8'd5;
      set_pal_index(base);
      for (int i = 0; i < 3; i++) pal_push(16'($random(seed)));
      apb_read(REG_PAL_INDEX, rd);
      check_byte("prdata pal_index", 8'(base + 8'd3), rd);
      set_bases(17'h00000, 17'h00100, 8'h10);
      vram_put(text_ref, 8'h41);
      vram_put(font_addr_of(8'h41, 3'd3), 8'hff);   // solid foreground
      for (int i = 0; i < 3; i++) begin
         vram_put(attr_ref, {4'h0, 4'(base + 8'(i))});
         render(1, 3'd3, ok);
         if (ok) begin
            for (int p = 0; p < 8; p++) check_pixel(p);
         end
      end
   endtask

   task automatic test_char_expand();
      logic [7:0] ch [4];
      logic [7:0] rd;
      logic       ok;
      set_pal_index(8'd0);
      for (int i = 0; i < 16; i++) pal_push(16'($random(seed)));
      // page 0x3f plus char[7] carries into vram bit 16
      set_bases(17'h00200, 17'h00300, 8'h3f);
      set_vaddr(text_ref);
      for (int c = 0; c < 4; c++) begin
         ch[c] = 8'($random(seed));
         if (c == 0) ch[c] = ch[c] | 8'h80;
         if (c == 1) ch[c] = ch[c] & 8'h7f;
         apb_write(REG_VDATA, ch[c]);
         vmem[text_ref + vram_addr_t'(c)] = ch[c];
      end
      apb_read(REG_VADDR_LO, rd);
      check_byte("prdata vaddr_lo", 8'h04, rd);
      vram_fill_random(attr_ref, 4);
      for (int c = 0; c < 4; c++) vram_put(font_addr_of(ch[c], 3'd6), 8'($random(seed)));
      render(4, 3'd6, ok);
      if (ok) begin
         for (int p = 0; p < 32; p++) check_pixel(p);
      end
   endtask

   task automatic test_busy_drop();
      logic [7:0] rd;
      logic       ok;
      logic       extra;
      apb_write(REG_COLS, 8'd20);
      apb_write(REG_START, 8'd0);
      apb_read(REG_STATUS, rd);
      check_byte("prdata status", 8'h01, rd);
      apb_write(REG_START, 8'd1);   // lands while busy
      wait_line_done(ok);
      extra = 1'b0;
      repeat (200) begin
         @(negedge sys_clk);
         if (line_done === 1'b1) extra = 1'b1;
      end
      check_bit("line_done", 1'b0, extra);
      apb_read(REG_STATUS, rd);
      check_bit("busy", 1'b0, rd[0]);
   endtask

   task automatic test_full_width();
      logic [7:0] ch;
      logic       ok;
      int         p;
      set_bases(17'h01000, 17'h01100, 8'h22);
      vram_fill_random(text_ref, 80);
      vram_fill_random(attr_ref, 80);
      for (int c = 0; c < 80; c++) begin
         ch = vmem[text_ref + vram_addr_t'(c)];
         vram_put(font_addr_of(ch, 3'd2), 8'($random(seed)));
      end
      render(80, 3'd2, ok);
      if (ok) begin
         check_pixel(639);
         for (int i = 0; i < 24; i++) begin
            p = int'($unsigned($random(seed)) % 640);
            check_pixel(p);
         end
      end
   endtask

   initial begin
      arst_n   = 1'b0;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      pix_addr = '0;
      pal_ptr  = '0;
      scan_ref = '0;
      errors   = 0;
      checks   = 0;
      tests    = 0;
      err_mark = 0;
      repeat (8) @(posedge sys_clk);
      arst_n <= 1'b1;
      test_reset_state();
      report_test("reset state");
      test_palette_load();
      report_test("palette load");
      test_char_expand();
      report_test("character expansion");
      test_busy_drop();
      report_test("busy and dropped start");
      test_full_width();
      report_test("full width line");
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) $display("TEST PASSED");
      else $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- text_video_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "text_video_macros.svh"

module text_video_top (
   input  logic                        sys_clk,
   input  logic                        arst_n,
   input  logic                        psel,
   input  logic                        penable,
   input  logic                        pwrite,
   input  logic [`APB_ADDR_W-1:0]      paddr,
   input  logic [7:0]                  pwdata,
   output logic [7:0]                  prdata,
   output logic                        pready,
   input  logic [`PIX_ADDR_W-1:0]      pix_addr,
   output video_render_pkg::color565_t pix_rgb,
   output logic                        line_done
);
   import video_render_pkg::*;

   vram_addr_t        text_base;
   vram_addr_t        attr_base;
   logic [7:0]        charset_base;
   logic [`COL_W-1:0] num_cols;
   logic              start;
   logic [2:0]        start_scan;
   logic              busy;
   logic              vram_we;
   vram_addr_t        vram_waddr;
   logic [7:0]        vram_wdata;
   vram_addr_t        vram_raddr;
   logic [7:0]        vram_rdata;
   logic              pal_we;
   pal_index_t        pal_waddr;
   color565_t         pal_wdata;
   logic              grp_we;
   logic [`COL_W-1:0] grp_col;
   logic [7:0]        grp_bits;
   nibble_t           grp_fg;
   nibble_t           grp_bg;

   apb_reg_file u_regs (
      .sys_clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .busy,
      .prdata, .pready, .text_base, .attr_base, .charset_base, .num_cols,
      .start, .start_scan, .vram_we, .vram_waddr, .vram_wdata,
      .pal_we, .pal_waddr, .pal_wdata
   );

   char_line_fetch u_fetch (
      .sys_clk, .arst_n, .start, .start_scan, .text_base, .attr_base,
      .charset_base, .num_cols, .vram_rdata, .busy, .vram_raddr,
      .grp_we, .grp_col, .grp_bits, .grp_fg, .grp_bg, .line_done
   );

   vram u_vram (
      .sys_clk, .we(vram_we), .waddr(vram_waddr), .wdata(vram_wdata),
      .raddr(vram_raddr), .rdata(vram_rdata)
   );

   line_buffer_palette u_line (
      .sys_clk, .grp_we, .grp_col, .grp_bits, .grp_fg, .grp_bg,
      .pal_we, .pal_waddr, .pal_wdata, .pix_addr, .pix_rgb
   );

endmodule

`default_nettype wire

//--- line_buffer_palette.sv
`timescale 1ns/1ps
`default_nettype none

`include "text_video_macros.svh"

module line_buffer_palette (
   input  logic                         sys_clk,
   input  logic                         grp_we,
   input  logic [`COL_W-1:0]            grp_col,
   input  logic [7:0]                   grp_bits,
   input  video_render_pkg::nibble_t    grp_fg,
   input  video_render_pkg::nibble_t    grp_bg,
   input  logic                         pal_we,
   input  video_render_pkg::pal_index_t pal_waddr,
   input  video_render_pkg::color565_t  pal_wdata,
   input  logic [`PIX_ADDR_W-1:0]       pix_addr,
   output video_render_pkg::color565_t  pix_rgb
);
   import video_render_pkg::*;

   pal_index_t line_idx [`LINE_PIXELS];
   color565_t  palette [`PAL_DEPTH];
   pal_index_t fg_idx;
   pal_index_t bg_idx;
   pal_index_t idx_q;

   assign fg_idx = {4'h0, grp_fg};
   assign bg_idx = {4'h0, grp_bg};

   // whole cell in one edge, bit 7 is the leftmost pixel
   always_ff @(posedge sys_clk) begin
      if (grp_we) begin
         for (int k = 0; k < 8; k++) begin
            line_idx[{grp_col, 3'(k)}] <= grp_bits[7-k] ? fg_idx : bg_idx;
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      idx_q <= line_idx[pix_addr];   // stage 1
   end

   always_ff @(posedge sys_clk) begin
      if (pal_we) palette[pal_waddr] <= pal_wdata;
      pix_rgb <= palette[idx_q];     // stage 2
   end

endmodule

`default_nettype wire

//--- char_line_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "text_video_macros.svh"

module char_line_fetch (
   input  logic                         sys_clk,
   input  logic                         arst_n,
   input  logic                         start,
   input  logic [2:0]                   start_scan,
   input  video_render_pkg::vram_addr_t text_base,
   input  video_render_pkg::vram_addr_t attr_base,
   input  logic [7:0]                   charset_base,
   input  logic [`COL_W-1:0]            num_cols,
   input  logic [7:0]                   vram_rdata,
   output logic                         busy,
   output video_render_pkg::vram_addr_t vram_raddr,
   output logic                         grp_we,
   output logic [`COL_W-1:0]            grp_col,
   output logic [7:0]                   grp_bits,
   output video_render_pkg::nibble_t    grp_fg,
   output video_render_pkg::nibble_t    grp_bg,
   output logic                         line_done
);
   import video_render_pkg::*;

   fetch_state_e     state;
   logic             step;    // 0 address cycle, 1 data cycle
   logic [`COL_W-1:0] col;
   logic [2:0]       scan;
   logic [7:0]       char_q;
   logic [7:0]       attr_q;
   logic [6:0]       font_page;
   vram_addr_t       font_addr;
   logic             last_col;

   assign last_col = col + 1'b1 >= num_cols;

   // codes 128..255 spill into the next 1 KiB charset page
   assign font_page = charset_base[6:0] + {6'd0, char_q[7]};
   assign font_addr = {font_page, char_q[6:0], scan};

   always_comb begin
      case (state)
         FETCH_ATTR:             vram_raddr = attr_base + vram_addr_t'(col);
         FETCH_FONT, FETCH_EMIT: vram_raddr = font_addr;
         default:                vram_raddr = text_base + vram_addr_t'(col);
      endcase
   end

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= FETCH_IDLE;
         step      <= 1'b0;
         col       <= '0;
         busy      <= 1'b0;
         grp_we    <= 1'b0;
         line_done <= 1'b0;
      end else begin
         grp_we    <= 1'b0;
         line_done <= 1'b0;
         case (state)
            FETCH_IDLE: begin
               if (start) begin
                  busy  <= 1'b1;
                  col   <= '0;
                  step  <= 1'b0;
                  state <= FETCH_CHAR;
               end
            end
            FETCH_CHAR: begin
               step <= ~step;
               if (step) state <= FETCH_ATTR;
            end
            FETCH_ATTR: begin
               step <= ~step;
               if (step) state <= FETCH_FONT;
            end
            FETCH_FONT: state <= FETCH_EMIT;
            FETCH_EMIT: begin
               grp_we <= 1'b1;
               if (last_col) begin
                  state <= FETCH_DONE;
               end else begin
                  col   <= col + 1'b1;
                  state <= FETCH_CHAR;
               end
            end
            FETCH_DONE: begin
               line_done <= 1'b1;
               busy      <= 1'b0;
               state     <= FETCH_IDLE;
            end
            default: state <= FETCH_IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (state == FETCH_IDLE && start) scan <= start_scan;   // held for the whole line
      if (state == FETCH_CHAR && step) char_q <= vram_rdata;
      if (state == FETCH_ATTR && step) attr_q <= vram_rdata;
      if (state == FETCH_EMIT) begin
         grp_bits <= vram_rdata;
         grp_fg   <= attr_q[3:0];
         grp_bg   <= attr_q[7:4];
         grp_col  <= col;
      end
   end

endmodule

`default_nettype wire

//--- vram.sv
`timescale 1ns/1ps
`default_nettype none

`include "text_video_macros.svh"

module vram (
   input  logic                         sys_clk,
   input  logic                         we,
   input  video_render_pkg::vram_addr_t waddr,
   input  logic [7:0]                   wdata,
   input  video_render_pkg::vram_addr_t raddr,
   output logic [7:0]                   rdata
);

   logic [7:0] mem [`VRAM_DEPTH];

   always_ff @(posedge sys_clk) begin
      if (we) mem[waddr] <= wdata;
   end

   // one cycle read latency
   always_ff @(posedge sys_clk) begin
      rdata <= mem[raddr];
   end

endmodule

`default_nettype wire

//--- apb_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "text_video_macros.svh"

module apb_reg_file (
   input  logic                         sys_clk,
   input  logic                         arst_n,
   input  logic                         psel,
   input  logic                         penable,
   input  logic                         pwrite,
   input  logic [`APB_ADDR_W-1:0]       paddr,
   input  logic [7:0]                   pwdata,
   input  logic                         busy,
   output logic [7:0]                   prdata,
   output logic                         pready,
   output video_render_pkg::vram_addr_t text_base,
   output video_render_pkg::vram_addr_t attr_base,
   output logic [7:0]                   charset_base,
   output logic [`COL_W-1:0]            num_cols,
   output logic                         start,
   output logic [2:0]                   start_scan,
   output logic                         vram_we,
   output video_render_pkg::vram_addr_t vram_waddr,
   output logic [7:0]                   vram_wdata,
   output logic                         pal_we,
   output video_render_pkg::pal_index_t pal_waddr,
   output video_render_pkg::color565_t  pal_wdata
);
   import video_regs_pkg::*;
   import video_render_pkg::*;

   pal_wr_state_e pal_state;
   pal_index_t    pal_index;
   color565_t     pal_value;
   vram_addr_t    vaddr;
   logic [7:0]    cols_wr;
   logic          wr_access;
   logic          wr_vdata;
   logic          wr_start;
   logic          wr_pal_data;

   assign pready      = 1'b1;   // no wait states
   assign wr_access   = psel & penable & pwrite;
   assign wr_vdata    = wr_access && paddr == REG_VDATA;
   assign wr_start    = wr_access && paddr == REG_START && !busy;   // dropped while rendering
   assign wr_pal_data = wr_access && paddr == REG_PAL_DATA;

   // column count kept in 1..80
   assign cols_wr = (pwdata == 8'd0) ? 8'd1 :
                    (pwdata > 8'(`MAX_COLS)) ? 8'(`MAX_COLS) : pwdata;

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         text_base    <= '0;
         attr_base    <= '0;
         charset_base <= '0;
         num_cols     <= {{(`COL_W-1){1'b0}}, 1'b1};
         vaddr        <= '0;
         pal_index    <= '0;
         pal_state    <= PAL_IDLE;
         vram_we      <= 1'b0;
         pal_we       <= 1'b0;
         start        <= 1'b0;
      end else begin
         vram_we <= wr_vdata;
         start   <= wr_start;
         pal_we  <= pal_state == PAL_COMMIT;
         if (pal_state == PAL_COMMIT) begin
            pal_index <= pal_index + 1'b1;   // next color lands in the next entry
            pal_state <= PAL_LO;
         end
         if (wr_access) begin
            case (paddr)
               REG_TEXT_LO:   text_base[7:0]  <= pwdata;
               REG_TEXT_MID:  text_base[15:8] <= pwdata;
               REG_TEXT_HI:   text_base[16]   <= pwdata[0];
               REG_ATTR_LO:   attr_base[7:0]  <= pwdata;
               REG_ATTR_MID:  attr_base[15:8] <= pwdata;
               REG_ATTR_HI:   attr_base[16]   <= pwdata[0];
               REG_CHARSET:   charset_base    <= pwdata;
               REG_COLS:      num_cols        <= cols_wr[`COL_W-1:0];
               REG_PAL_INDEX: begin
                  pal_index <= pwdata;
                  pal_state <= PAL_LO;
               end
               REG_PAL_DATA: begin
                  if (pal_state == PAL_LO) pal_state <= PAL_HI;
                  else if (pal_state == PAL_HI) pal_state <= PAL_COMMIT;
               end
               REG_VADDR_LO:  vaddr[7:0]  <= pwdata;
               REG_VADDR_MID: vaddr[15:8] <= pwdata;
               REG_VADDR_HI:  vaddr[16]   <= pwdata[0];
               REG_VDATA:     vaddr       <= vaddr + 1'b1;
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (wr_vdata) begin
         vram_waddr <= vaddr;
         vram_wdata <= pwdata;
      end
      if (wr_start) start_scan <= pwdata[2:0];
      if (wr_pal_data && pal_state == PAL_LO) pal_value[7:0]  <= pwdata;
      if (wr_pal_data && pal_state == PAL_HI) pal_value[15:8] <= pwdata;
      if (pal_state == PAL_COMMIT) begin
         pal_waddr <= pal_index;
         pal_wdata <= pal_value;
      end
   end

   always_comb begin
      case (paddr)
         REG_TEXT_LO:   prdata = text_base[7:0];
         REG_TEXT_MID:  prdata = text_base[15:8];
         REG_TEXT_HI:   prdata = {7'b0, text_base[16]};
         REG_ATTR_LO:   prdata = attr_base[7:0];
         REG_ATTR_MID:  prdata = attr_base[15:8];
         REG_ATTR_HI:   prdata = {7'b0, attr_base[16]};
         REG_CHARSET:   prdata = charset_base;
         REG_COLS:      prdata = 8'(num_cols);
         REG_PAL_INDEX: prdata = pal_index;
         REG_VADDR_LO:  prdata = vaddr[7:0];
         REG_VADDR_MID: prdata = vaddr[15:8];
         REG_VADDR_HI:  prdata = {7'b0, vaddr[16]};
         REG_STATUS:    prdata = {7'b0, busy};
         default:       prdata = 8'h00;
      endcase
   end

endmodule

`default_nettype wire

//--- video_render_pkg.sv
`default_nettype none

`include "text_video_macros.svh"

package video_render_pkg;

   // per column walk of the fetcher
   typedef enum logic [2:0] {
      FETCH_IDLE,
      FETCH_CHAR,    // two cycles, address then data
      FETCH_ATTR,    // two cycles, address then data
      FETCH_FONT,    // font address cycle
      FETCH_EMIT,    // font data, group goes out
      FETCH_DONE
   } fetch_state_e;

   typedef logic [`VRAM_ADDR_W-1:0] vram_addr_t;
   typedef logic [15:0] color565_t;   // r[15:11] g[10:5] b[4:0]
   typedef logic [7:0]  pal_index_t;
   typedef logic [3:0]  nibble_t;     // fg or bg color of one cell

endpackage

`default_nettype wire

//--- video_regs_pkg.sv
`default_nettype none

package video_regs_pkg;

   // cpu register map, byte wide registers
   typedef enum logic [7:0] {
      REG_TEXT_LO   = 8'h00,
      REG_TEXT_MID  = 8'h01,
      REG_TEXT_HI   = 8'h02,   // bit 0 only
      REG_ATTR_LO   = 8'h03,
      REG_ATTR_MID  = 8'h04,
      REG_ATTR_HI   = 8'h05,
      REG_CHARSET   = 8'h06,
      REG_COLS      = 8'h07,
      REG_PAL_INDEX = 8'h08,
      REG_PAL_DATA  = 8'h09,   // low byte then high byte
      REG_VADDR_LO  = 8'h0a,
      REG_VADDR_MID = 8'h0b,
      REG_VADDR_HI  = 8'h0c,
      REG_VDATA     = 8'h0d,   // write bumps the vram address
      REG_START     = 8'h10,   // wdata[2:0] is the font scanline
      REG_STATUS    = 8'h11    // bit 0 busy
   } reg_addr_e;

   typedef enum logic [1:0] {PAL_IDLE, PAL_LO, PAL_HI, PAL_COMMIT} pal_wr_state_e;

endpackage

`default_nettype wire

//--- text_video_macros.svh
`ifndef TEXT_VIDEO_MACROS_SVH
`define TEXT_VIDEO_MACROS_SVH

// video memory, one byte per address
`define VRAM_ADDR_W 17
`define VRAM_DEPTH  131072

// one scanline: 80 columns of 8 pixels
`define LINE_PIXELS 640
`define PIX_ADDR_W  10
`define MAX_COLS    80
`define COL_W       7

`define PAL_DEPTH   256   // rgb565 entries

`define APB_ADDR_W  8

`endif
